// File: files.f
+incdir+hdl
hdl/net_pkg.sv
hdl/ctrl_pkg.sv
hdl/job_sequencer.sv
hdl/char_receiver.sv
hdl/embed_layer.sv
hdl/mix_layer.sv
hdl/output_layer.sv
hdl/char_sender.sv
hdl/seq_top.sv
tests/seq_assert.sv
tests/seq_tb.sv

// File: hdl/char_receiver.sv
`include "seq_defs.svh"

module char_receiver
  import net_pkg::*;
(
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            run,
  input  char_t                           s_data,
  input  logic                            s_valid,
  output logic                            s_ready,
  output logic                            done,
  output logic [`SEQ_N*`SEQ_CHAR_LEN-1:0] frame
);

  localparam int CNT_W = $clog2(`SEQ_N + 1);
  localparam int POS_W = $clog2(`SEQ_N);

  logic [CNT_W-1:0] cnt;
  logic             xfer;

  assign s_ready = run && (cnt != CNT_W'(`SEQ_N));
  assign xfer    = s_ready && s_valid;

  // position counter, cleared once the stage is left
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt  <= '0;
      done <= 1'b0;
    end else begin
      done <= xfer && (cnt == CNT_W'(`SEQ_N - 1));
      if (!run) begin
        cnt <= '0;
      end else if (xfer) begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (xfer) begin
      frame[cnt[POS_W-1:0]*`SEQ_CHAR_LEN +: `SEQ_CHAR_LEN] <= s_data;
    end
  end

endmodule

// File: hdl/char_sender.sv
`include "seq_defs.svh"

module char_sender
  import net_pkg::*;
(
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            run,
  input  logic [`SEQ_N*`SEQ_CHAR_LEN-1:0] result,
  output char_t                           m_data,
  output logic                            m_valid,
  output logic                            m_last,
  input  logic                            m_ready,
  output logic                            done
);

  localparam int IDX_W = $clog2(`SEQ_N + 1);
  localparam int POS_W = $clog2(`SEQ_N);

  logic [IDX_W-1:0] idx;
  logic             xfer;

  // valid until all four have gone, data follows the index
  assign m_valid = run && (idx != IDX_W'(`SEQ_N));
  assign m_data  = result[idx[POS_W-1:0]*`SEQ_CHAR_LEN +: `SEQ_CHAR_LEN];
  assign m_last  = m_valid && (idx == IDX_W'(`SEQ_N - 1));
  assign xfer    = m_valid && m_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      idx  <= '0;
      done <= 1'b0;
    end else begin
      done <= xfer && m_last;
      if (!run) begin
        idx <= '0;
      end else if (xfer) begin
        idx <= idx + 1'b1;
      end
    end
  end

endmodule

// File: hdl/ctrl_pkg.sv
package ctrl_pkg;

  typedef enum logic {
    FORWARD    = 1'b0,
    REGENERATE = 1'b1
  } job_mode_t;

  // job steps in the order a forward job runs them
  typedef enum logic [2:0] {
    IDLE = 3'd0,
    RECV = 3'd1,
    EMB  = 3'd2,
    MIX  = 3'd3,
    OUT  = 3'd4,
    SEND = 3'd5,
    FIN  = 3'd6
  } seq_state_t;

endpackage

// File: hdl/embed_layer.sv
`include "seq_defs.svh"

module embed_layer
  import net_pkg::*;
(
  input  logic                                        clk,
  input  logic                                        arst_n,
  input  logic                                        run,
  input  logic [`SEQ_N*`SEQ_CHAR_LEN-1:0]             frame,
  output logic                                        done,
  output logic [`SEQ_N*`SEQ_EMB_DIM*`SEQ_ACT_LEN-1:0] emb
);

  localparam int W = `SEQ_ACT_LEN;

  logic run_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      run_q <= 1'b0;
      done  <= 1'b0;
    end else begin
      run_q <= run;
      done  <= run && !run_q;
    end
  end

  // lookup per position, both dimensions side by side
  always_ff @(posedge clk) begin
    if (run) begin
      for (int p = 0; p < `SEQ_N; p++) begin
        emb[(p*`SEQ_EMB_DIM)*W +: W]     <= emb_dim0(frame[p*`SEQ_CHAR_LEN +: `SEQ_CHAR_LEN]);
        emb[(p*`SEQ_EMB_DIM + 1)*W +: W] <= emb_dim1(frame[p*`SEQ_CHAR_LEN +: `SEQ_CHAR_LEN]);
      end
    end
  end

endmodule

// File: hdl/job_sequencer.sv
module job_sequencer
  import ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       run_req,
  input  job_mode_t  run_mode,
  output logic       run_ack,
  input  logic       recv_done,
  input  logic       emb_done,
  input  logic       mix_done,
  input  logic       out_done,
  input  logic       send_done,
  output seq_state_t state,
  output logic       from_emb
);

  seq_state_t state_nxt;
  logic       stage_done;

  // done of the stage that owns the current state
  always_comb begin
    case (state)
      RECV:    stage_done = recv_done;
      EMB:     stage_done = emb_done;
      MIX:     stage_done = mix_done;
      OUT:     stage_done = out_done;
      SEND:    stage_done = send_done;
      default: stage_done = 1'b0;
    endcase
  end

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (run_req) begin
          if (run_mode == FORWARD) begin
            state_nxt = RECV;
          end else begin
            // regenerate skips receive and embedding
            state_nxt = MIX;
          end
        end
      end
      RECV: if (stage_done) state_nxt = EMB;
      EMB:  if (stage_done) state_nxt = MIX;
      MIX:  if (stage_done) state_nxt = OUT;
      OUT:  if (stage_done) state_nxt = SEND;
      SEND: if (stage_done) state_nxt = FIN;
      // hold ack until the host drops its request
      FIN:  if (!run_req) state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= IDLE;
      from_emb <= 1'b0;
    end else begin
      state <= state_nxt;
      if (state == IDLE && run_req) begin
        from_emb <= (run_mode == FORWARD);
      end
    end
  end

  assign run_ack = (state == FIN);

endmodule

// File: hdl/mix_layer.sv
`include "seq_defs.svh"

module mix_layer
  import net_pkg::*;
(
  input  logic                                        clk,
  input  logic                                        arst_n,
  input  logic                                        run,
  input  logic                                        from_emb,
  input  logic [`SEQ_N*`SEQ_EMB_DIM*`SEQ_ACT_LEN-1:0] emb,
  output logic                                        done,
  output logic [`SEQ_N*`SEQ_EMB_DIM*`SEQ_ACT_LEN-1:0] mix
);

  localparam int W       = `SEQ_ACT_LEN;
  localparam int PASS_W  = $clog2(`SEQ_MIX_PASSES + 1);
  // room for the full sum of all positions
  localparam int SUM_LEN = `SEQ_ACT_LEN + $clog2(`SEQ_N);
  localparam logic signed [SUM_LEN-1:0] ACT_MAX = (1 <<< (`SEQ_ACT_LEN - 1)) - 1;
  localparam logic signed [SUM_LEN-1:0] ACT_MIN = -(1 <<< (`SEQ_ACT_LEN - 1));

  logic [PASS_W-1:0]                            pass_cnt;
  logic [`SEQ_N*`SEQ_EMB_DIM*`SEQ_ACT_LEN-1:0] mix_src;
  logic [`SEQ_N*`SEQ_EMB_DIM*`SEQ_ACT_LEN-1:0] mix_nxt;

  function automatic act_t sat_act(input logic signed [SUM_LEN-1:0] v);
    act_t r;
    if (v > ACT_MAX) begin
      r = act_t'(ACT_MAX);
    end else if (v < ACT_MIN) begin
      r = act_t'(ACT_MIN);
    end else begin
      r = act_t'(v);
    end
    return r;
  endfunction

  // prefix sum over positions, per dimension
  always_comb begin
    logic signed [SUM_LEN-1:0] acc;
    mix_src = (from_emb && pass_cnt == '0) ? emb : mix;
    for (int d = 0; d < `SEQ_EMB_DIM; d++) begin
      acc = '0;
      for (int p = 0; p < `SEQ_N; p++) begin
        acc = acc + act_t'(mix_src[(p*`SEQ_EMB_DIM + d)*W +: W]);
        mix_nxt[(p*`SEQ_EMB_DIM + d)*W +: W] = sat_act(acc);
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pass_cnt <= '0;
      done     <= 1'b0;
      mix      <= '0;
    end else begin
      done <= 1'b0;
      if (!run) begin
        pass_cnt <= '0;
      end else if (pass_cnt != PASS_W'(`SEQ_MIX_PASSES)) begin
        mix      <= mix_nxt;
        pass_cnt <= pass_cnt + 1'b1;
        done     <= (pass_cnt == PASS_W'(`SEQ_MIX_PASSES - 1));
      end
    end
  end

endmodule

// File: hdl/net_pkg.sv
`include "seq_defs.svh"

package net_pkg;

  typedef logic [`SEQ_CHAR_LEN-1:0]         char_t;
  typedef logic signed [`SEQ_ACT_LEN-1:0]   act_t;
  typedef logic signed [`SEQ_SCORE_LEN-1:0] score_t;

  // embedding dimension 0 is c minus 4
  function automatic act_t emb_dim0(input char_t c);
    return act_t'(c) - act_t'(4);
  endfunction

  // embedding dimension 1 is (c squared mod 7) minus 3
  function automatic act_t emb_dim1(input char_t c);
    act_t v;
    v = act_t'(c);
    return act_t'((v * v) % act_t'(7)) - act_t'(3);
  endfunction

endpackage

// File: hdl/output_layer.sv
`include "seq_defs.svh"

module output_layer
  import net_pkg::*;
(
  input  logic                                        clk,
  input  logic                                        arst_n,
  input  logic                                        run,
  input  logic [`SEQ_N*`SEQ_EMB_DIM*`SEQ_ACT_LEN-1:0] mix,
  output logic                                        done,
  output logic [`SEQ_N*`SEQ_CHAR_LEN-1:0]             result
);

  localparam int W  = `SEQ_ACT_LEN;
  localparam int CL = `SEQ_CHAR_LEN;
  localparam score_t SCORE_MIN = {1'b1, {(`SEQ_SCORE_LEN-1){1'b0}}};

  logic                            run_q;
  logic [`SEQ_N*`SEQ_CHAR_LEN-1:0] result_nxt;

  // dense score against the embedding table, then argmax
  always_comb begin
    score_t best;
    score_t score;
    char_t  best_c;
    act_t   x0;
    act_t   x1;
    for (int p = 0; p < `SEQ_N; p++) begin
      x0     = act_t'(mix[(p*`SEQ_EMB_DIM)*W +: W]);
      x1     = act_t'(mix[(p*`SEQ_EMB_DIM + 1)*W +: W]);
      best   = SCORE_MIN;
      best_c = '0;
      for (int c = 0; c < `SEQ_CHAR_NUM; c++) begin
        score = score_t'(x0) * score_t'(emb_dim0(char_t'(c)))
              + score_t'(x1) * score_t'(emb_dim1(char_t'(c)));
        // strict compare keeps the lowest code on a tie
        if (score > best) begin
          best   = score;
          best_c = char_t'(c);
        end
      end
      result_nxt[p*CL +: CL] = best_c;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      run_q <= 1'b0;
      done  <= 1'b0;
    end else begin
      run_q <= run;
      done  <= run && !run_q;
    end
  end

  always_ff @(posedge clk) begin
    if (run) begin
      result <= result_nxt;
    end
  end

endmodule

// File: hdl/seq_defs.svh
`ifndef SEQ_DEFS_SVH
`define SEQ_DEFS_SVH

// frame and alphabet
`define SEQ_N          4
`define SEQ_CHAR_NUM   8
`define SEQ_CHAR_LEN   3

// embedding width, two dimensions per character
`define SEQ_EMB_DIM    2

// arithmetic widths
`define SEQ_ACT_LEN    8
`define SEQ_SCORE_LEN  16

// token mixing passes per job
`define SEQ_MIX_PASSES 2

`endif

// File: hdl/seq_top.sv
`include "seq_defs.svh"

module seq_top
  import net_pkg::*;
  import ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  logic      run_req,
  input  job_mode_t run_mode,
  output logic      run_ack,
  input  char_t     s_data,
  input  logic      s_valid,
  output logic      s_ready,
  output char_t     m_data,
  output logic      m_valid,
  input  logic      m_ready,
  output logic      m_last
);

  // --------------------------------------------------------------------------
  // sequencer
  seq_state_t state;
  logic       from_emb;

  logic recv_run, recv_done;
  logic emb_run, emb_done;
  logic mix_run, mix_done;
  logic out_run, out_done;
  logic send_run, send_done;

  // stage data
  logic [`SEQ_N*`SEQ_CHAR_LEN-1:0]             frame;
  logic [`SEQ_N*`SEQ_EMB_DIM*`SEQ_ACT_LEN-1:0] emb;
  logic [`SEQ_N*`SEQ_EMB_DIM*`SEQ_ACT_LEN-1:0] mix;
  logic [`SEQ_N*`SEQ_CHAR_LEN-1:0]             result;

  // one run per stage
  assign recv_run = (state == RECV);
  assign emb_run  = (state == EMB);
  assign mix_run  = (state == MIX);
  assign out_run  = (state == OUT);
  assign send_run = (state == SEND);

  job_sequencer i_job_sequencer (
    .clk       (clk),
    .arst_n    (arst_n),
    .run_req   (run_req),
    .run_mode  (run_mode),
    .run_ack   (run_ack),
    .recv_done (recv_done),
    .emb_done  (emb_done),
    .mix_done  (mix_done),
    .out_done  (out_done),
    .send_done (send_done),
    .state     (state),
    .from_emb  (from_emb)
  );

  // --------------------------------------------------------------------------
  // datapath
  char_receiver i_char_receiver (
    .clk     (clk),
    .arst_n  (arst_n),
    .run     (recv_run),
    .s_data  (s_data),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .done    (recv_done),
    .frame   (frame)
  );

  embed_layer i_embed_layer (
    .clk    (clk),
    .arst_n (arst_n),
    .run    (emb_run),
    .frame  (frame),
    .done   (emb_done),
    .emb    (emb)
  );

  mix_layer i_mix_layer (
    .clk      (clk),
    .arst_n   (arst_n),
    .run      (mix_run),
    .from_emb (from_emb),
    .emb      (emb),
    .done     (mix_done),
    .mix      (mix)
  );

  output_layer i_output_layer (
    .clk    (clk),
    .arst_n (arst_n),
    .run    (out_run),
    .mix    (mix),
    .done   (out_done),
    .result (result)
  );

  char_sender i_char_sender (
    .clk     (clk),
    .arst_n  (arst_n),
    .run     (send_run),
    .result  (result),
    .m_data  (m_data),
    .m_valid (m_valid),
    .m_last  (m_last),
    .m_ready (m_ready),
    .done    (send_done)
  );

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module seq_tb -o seq_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/seq_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx 'Result: PASSED'; then
  exit 0
fi
exit 1

// File: tests/seq_assert.sv
module seq_assert
  import net_pkg::*;
  import ctrl_pkg::*;
(
  input logic       clk,
  input logic       arst_n,
  input logic       run_req,
  input logic       run_ack,
  input seq_state_t state,
  input logic       m_valid,
  input logic       m_ready,
  input char_t      m_data
);

  // ack holds as long as the request is up
  ack_holds: assert property (@(posedge clk) disable iff (!arst_n)
    run_ack && run_req |=> run_ack)
    else $error("run_ack fell while run_req was still high");

  // back-pressure keeps the current character on the bus
  stall_data: assert property (@(posedge clk) disable iff (!arst_n)
    m_valid && !m_ready |=> m_valid && $stable(m_data))
    else $error("m_data or m_valid changed while m_ready was low");

  reset_idle: assert property (@(posedge clk)
    !arst_n |=> state == IDLE && !run_ack)
    else $error("sequencer not idle with run_ack low after reset");

endmodule

// ----------------------------------------------------------------------------
// command side on the sequencer, stream side on the sender

bind job_sequencer seq_assert i_seq_assert (
  .clk     (clk),
  .arst_n  (arst_n),
  .run_req (run_req),
  .run_ack (run_ack),
  .state   (state),
  .m_valid (1'b0),
  .m_ready (1'b0),
  .m_data  ('0)
);

bind char_sender seq_assert i_seq_assert (
  .clk     (clk),
  .arst_n  (arst_n),
  .run_req (1'b0),
  .run_ack (1'b0),
  .state   (ctrl_pkg::IDLE),
  .m_valid (m_valid),
  .m_ready (m_ready),
  .m_data  (m_data)
);

// File: tests/seq_tb.sv
`include "seq_defs.svh"

module seq_tb
  import net_pkg::*;
  import ctrl_pkg::*;
();

  localparam int FRAME_W        = `SEQ_N * `SEQ_CHAR_LEN;
  localparam int ACT_MAX        = (1 << (`SEQ_ACT_LEN - 1)) - 1;
  localparam int ACT_MIN        = -(1 << (`SEQ_ACT_LEN - 1));
  localparam int RESET_CYCLES   = 5;
  // 34 jobs are run and the limit leaves headroom for long stalls
  localparam int TIMEOUT_CYCLES = 40 * 60;

  logic      clk;
  logic      arst_n;
  logic      run_req;
  job_mode_t run_mode;
  logic      run_ack;
  char_t     s_data;
  logic      s_valid;
  logic      s_ready;
  char_t     m_data;
  logic      m_valid;
  logic      m_ready;
  logic      m_last;

  logic [15:0] lfsr;
  int          cycles;
  int          out_idx;
  logic        ended;
  char_t       exp_q[$];
  // model copy of the mix state carried between jobs
  int          mdl_mix [`SEQ_N][`SEQ_EMB_DIM];

  seq_top i_seq_top (
    .clk      (clk),
    .arst_n   (arst_n),
    .run_req  (run_req),
    .run_mode (run_mode),
    .run_ack  (run_ack),
    .s_data   (s_data),
    .s_valid  (s_valid),
    .s_ready  (s_ready),
    .m_data   (m_data),
    .m_valid  (m_valid),
    .m_ready  (m_ready),
    .m_last   (m_last)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // random source and reference model

  function automatic logic rand_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) begin
      lfsr = lfsr ^ 16'hB400;
    end
    return b;
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(rand_bit());
    end
    return v;
  endfunction

  function automatic logic [FRAME_W-1:0] rand_frame();
    logic [FRAME_W-1:0] f;
    f = '0;
    for (int p = 0; p < `SEQ_N; p++) begin
      f[p*`SEQ_CHAR_LEN +: `SEQ_CHAR_LEN] = char_t'(rand_bits(`SEQ_CHAR_LEN));
    end
    return f;
  endfunction

  function automatic int ref_e0(input int c);
    return c - 4;
  endfunction

  function automatic int ref_e1(input int c);
    return (c * c) % 7 - 3;
  endfunction

  function automatic int clip_act(input int v);
    if (v > ACT_MAX) begin
      return ACT_MAX;
    end
    if (v < ACT_MIN) begin
      return ACT_MIN;
    end
    return v;
  endfunction

  function automatic logic [FRAME_W-1:0] model_job(input job_mode_t mode,
                                                   input logic [FRAME_W-1:0] frm);
    logic [FRAME_W-1:0] res;
    int                 c;
    int                 sum;
    int                 score;
    int                 best;
    int                 best_c;
    res = '0;
    if (mode == FORWARD) begin
      for (int p = 0; p < `SEQ_N; p++) begin
        c = int'(frm[p*`SEQ_CHAR_LEN +: `SEQ_CHAR_LEN]);
        mdl_mix[p][0] = ref_e0(c);
        mdl_mix[p][1] = ref_e1(c);
      end
    end
    // each position becomes the clipped sum of itself and all before it
    for (int k = 0; k < `SEQ_MIX_PASSES; k++) begin
      for (int d = 0; d < `SEQ_EMB_DIM; d++) begin
        sum = 0;
        for (int p = 0; p < `SEQ_N; p++) begin
          sum = sum + mdl_mix[p][d];
          mdl_mix[p][d] = clip_act(sum);
        end
      end
    end
    for (int p = 0; p < `SEQ_N; p++) begin
      best   = mdl_mix[p][0] * ref_e0(0) + mdl_mix[p][1] * ref_e1(0);
      best_c = 0;
      for (int k = 1; k < `SEQ_CHAR_NUM; k++) begin
        score = mdl_mix[p][0] * ref_e0(k) + mdl_mix[p][1] * ref_e1(k);
        if (score > best) begin
          best   = score;
          best_c = k;
        end
      end
      res[p*`SEQ_CHAR_LEN +: `SEQ_CHAR_LEN] = char_t'(best_c);
    end
    return res;
  endfunction

  // --------------------------------------------------------------------------
  // checks

  task automatic fail_run(input string why);
    ended = 1'b1;
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_char(input string name, input char_t got, input char_t exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_quiet();
    check_bit("run_ack", run_ack, 1'b0);
    check_bit("s_ready", s_ready, 1'b0);
    check_bit("m_valid", m_valid, 1'b0);
  endtask

  // every output transfer against the queue of model results
  initial begin
    out_idx = 0;
    forever begin
      @(negedge clk);
      if (arst_n && m_valid && m_ready) begin
        if (exp_q.size() == 0) begin
          fail_run("an output character was sent with no result expected");
        end else begin
          check_char("m_data", m_data, exp_q.pop_front());
          check_bit("m_last", m_last, out_idx == `SEQ_N - 1);
          out_idx = (out_idx + 1) % `SEQ_N;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > TIMEOUT_CYCLES) begin
      fail_run("timeout, the job sequence did not complete in time");
    end
  end

  // an assertion that stops the run leaves ended low
  final begin
    if (!ended) begin
      $display("simulation stopped before the test sequence completed");
      $display("Result: FAILED");
    end
  end

  // --------------------------------------------------------------------------
  // stimulus

  // next cycle with inputs changed 1 unit after the edge
  task automatic tick();
    @(posedge clk);
    #1;
    m_ready = rand_bit() | rand_bit();
  endtask

  task automatic run_job(input job_mode_t mode, input logic [FRAME_W-1:0] frm);
    logic [FRAME_W-1:0] exp;
    int                 n;
    logic               taken;
    logic               acked;
    exp = model_job(mode, frm);
    for (int p = 0; p < `SEQ_N; p++) begin
      exp_q.push_back(char_t'(exp[p*`SEQ_CHAR_LEN +: `SEQ_CHAR_LEN]));
    end
    tick();
    run_mode = mode;
    run_req  = 1'b1;
    n        = 0;
    taken    = 1'b1;
    acked    = 1'b0;
    while (!acked) begin
      if (mode == FORWARD && n < `SEQ_N) begin
        // valid holds until the character is taken
        if (taken || !s_valid) begin
          s_valid = rand_bit();
        end
        s_data = char_t'(frm[n*`SEQ_CHAR_LEN +: `SEQ_CHAR_LEN]);
      end else begin
        s_valid = 1'b0;
      end
      @(negedge clk);
      taken = s_valid && s_ready;
      if (taken) begin
        n++;
      end
      if (mode == REGENERATE) begin
        check_bit("s_ready", s_ready, 1'b0);
      end
      acked = run_ack;
      if (!acked) begin
        tick();
      end
    end
    if (n != ((mode == FORWARD) ? `SEQ_N : 0)) begin
      fail_run("run_ack rose with the wrong number of input characters taken");
    end
    if (exp_q.size() != 0) begin
      fail_run("run_ack rose before all four results were sent");
    end
    tick();
    run_req = 1'b0;
    @(negedge clk);
    while (run_ack) begin
      tick();
      @(negedge clk);
    end
  endtask

  initial begin
    logic [FRAME_W-1:0] frm;
    lfsr     = 16'd45711;
    cycles   = 0;
    ended    = 1'b0;
    arst_n   = 1'b0;
    run_req  = 1'b0;
    run_mode = FORWARD;
    s_data   = '0;
    s_valid  = 1'b0;
    m_ready  = 1'b0;
    for (int p = 0; p < `SEQ_N; p++) begin
      mdl_mix[p][0] = 0;
      mdl_mix[p][1] = 0;
    end

    repeat (RESET_CYCLES) begin
      tick();
      check_quiet();
    end
    arst_n = 1'b1;
    // quiet after reset with no request
    repeat (3) begin
      @(negedge clk);
      check_quiet();
      tick();
    end

    repeat (10) begin
      run_job(FORWARD, rand_frame());
    end

    // regenerate runs on the mix state of the job before
    repeat (6) begin
      frm = rand_frame();
      run_job(FORWARD, frm);
      run_job(REGENERATE, frm);
    end

    // repeated mixing pushes activations into both limits
    run_job(FORWARD, '0);
    repeat (5) begin
      run_job(REGENERATE, '0);
    end
    run_job(FORWARD, {`SEQ_N{3'd7}});
    repeat (5) begin
      run_job(REGENERATE, '0);
    end

    tick();
    ended = 1'b1;
    $display("Result: PASSED");
    $finish;
  end

endmodule
